// ==== logic/cgra_pkg.sv ====
`default_nettype none

package cgra_pkg;

  localparam int DATA_W  = 16;
  localparam int INSTR_W = 16;
  localparam int RF_AW   = 3;
  localparam int PC_W    = 8;
  localparam int CONF_W  = 64;
  localparam int ID_W    = 8;
  localparam int CNT_W   = 8;

  typedef enum logic [3:0] {
    op_add    = 4'd0,
    op_sub    = 4'd1,
    op_mul    = 4'd2,  // low half of the product.
    op_and    = 4'd3,
    op_or     = 4'd4,
    op_xor    = 4'd5,
    op_shl    = 4'd6,
    op_shr    = 4'd7,
    op_min    = 4'd8,
    op_max    = 4'd9,
    op_pass_a = 4'd10
  } alu_op_e;

  typedef enum logic [1:0] {src_in_a, src_in_b, src_rf, src_fifo} src_e;
  typedef enum logic [1:0] {dst_out_a, dst_out_b, dst_rf, dst_fifo} dst_e;

  typedef enum logic [3:0] {
    cmd_instr  = 4'd1,  // code 0 is an idle bus.
    cmd_const  = 4'd2,
    cmd_pc     = 4'd3,
    cmd_ignore = 4'd4
  } conf_cmd_e;

  ////////////////////
  // instruction word fields
  localparam int I_OP_MSB    = 15;
  localparam int I_OP_LSB    = 12;
  localparam int I_SRCA_MSB  = 11;
  localparam int I_SRCA_LSB  = 10;
  localparam int I_SRCB_MSB  = 9;
  localparam int I_SRCB_LSB  = 8;
  localparam int I_DST_MSB   = 7;
  localparam int I_DST_LSB   = 6;
  localparam int I_RADDR_MSB = 5;
  localparam int I_RADDR_LSB = 3;
  localparam int I_WADDR_MSB = 2;
  localparam int I_WADDR_LSB = 0;

  ////////////////////
  // configuration word fields
  localparam int C_ID_MSB   = 63;
  localparam int C_ID_LSB   = 56;
  localparam int C_CMD_MSB  = 55;
  localparam int C_CMD_LSB  = 52;
  localparam int C_ADDR_MSB = 39;  // also pc_max.
  localparam int C_ADDR_LSB = 32;
  localparam int C_LOOP_MSB = 31;  // also the ignore count.
  localparam int C_LOOP_LSB = 24;
  localparam int C_DATA_MSB = 15;
  localparam int C_DATA_LSB = 0;

endpackage

`default_nettype wire

// ==== logic/pe_ctrl_if.sv ====
`default_nettype none

interface pe_ctrl_if;
  import cgra_pkg::*;

  alu_op_e          op;
  src_e             src_a;
  src_e             src_b;
  dst_e             dst;
  logic [RF_AW-1:0] rf_raddr;
  logic [RF_AW-1:0] rf_waddr;

  modport decode (
    output op,
    output src_a,
    output src_b,
    output dst,
    output rf_raddr,
    output rf_waddr
  );

  modport execute (
    input op,
    input src_a,
    input src_b,
    input dst,
    input rf_raddr,
    input rf_waddr
  );

endinterface

`default_nettype wire

// ==== logic/pe_conf_loader.sv ====
`default_nettype none

module pe_conf_loader #(
  parameter int PE_ID = 0
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [cgra_pkg::CONF_W-1:0]   conf_bus_in,
  output logic                          instr_we,
  output logic [cgra_pkg::PC_W-1:0]     instr_addr,
  output logic [cgra_pkg::INSTR_W-1:0]  instr_data,
  output logic                          const_we,
  output logic [cgra_pkg::RF_AW-1:0]    const_addr,
  output logic [cgra_pkg::DATA_W-1:0]   const_data,
  output logic [cgra_pkg::PC_W-1:0]     pc_max,
  output logic [cgra_pkg::PC_W-1:0]     pc_loop,
  output logic [cgra_pkg::CNT_W-1:0]    ignore_count
);
  import cgra_pkg::*;

  logic      hit;
  conf_cmd_e cmd;

  assign hit = conf_bus_in[C_ID_MSB:C_ID_LSB] == ID_W'(PE_ID);
  assign cmd = conf_cmd_e'(conf_bus_in[C_CMD_MSB:C_CMD_LSB]);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      instr_we     <= 1'b0;
      const_we     <= 1'b0;
      pc_max       <= '0;
      pc_loop      <= '0;
      ignore_count <= '0;
    end else begin
      instr_we <= hit && (cmd == cmd_instr);  // one-cycle strobes.
      const_we <= hit && (cmd == cmd_const);
      if (hit && (cmd == cmd_pc)) begin
        pc_max  <= conf_bus_in[C_ADDR_MSB:C_ADDR_LSB];
        pc_loop <= conf_bus_in[C_LOOP_MSB:C_LOOP_LSB];
      end
      if (hit && (cmd == cmd_ignore)) begin
        ignore_count <= conf_bus_in[C_LOOP_MSB:C_LOOP_LSB];
      end
    end
  end

  // write payload, qualified by the strobes.
  always_ff @(posedge clk) begin
    instr_addr <= conf_bus_in[C_ADDR_MSB:C_ADDR_LSB];
    instr_data <= conf_bus_in[C_DATA_MSB:C_DATA_LSB];
    const_addr <= conf_bus_in[C_ADDR_LSB +: RF_AW];
    const_data <= conf_bus_in[C_DATA_MSB:C_DATA_LSB];
  end

  a_one_strobe : assert property (@(posedge clk) disable iff (!rst_n)
    !(instr_we && const_we));

endmodule

`default_nettype wire

// ==== logic/pe_decode.sv ====
`default_nettype none

module pe_decode (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          en,
  input  logic                          instr_we,
  input  logic [cgra_pkg::PC_W-1:0]     instr_addr,
  input  logic [cgra_pkg::INSTR_W-1:0]  instr_data,
  input  logic [cgra_pkg::PC_W-1:0]     pc_max,
  input  logic [cgra_pkg::PC_W-1:0]     pc_loop,
  pe_ctrl_if.decode                     ctrl
);
  import cgra_pkg::*;

  logic [INSTR_W-1:0] imem [2**PC_W];
  logic [PC_W-1:0]    pc;
  logic [INSTR_W-1:0] instr_q;
  logic               loaded;
  logic               instr_vld;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= '0;
    end else if (en) begin
      if (pc >= pc_max) begin
        pc <= pc_loop;  // wrap back into the loop body.
      end else begin
        pc <= pc + 1'b1;
      end
    end
  end

  ////////////////////
  // instruction memory
  always_ff @(posedge clk) begin
    if (instr_we) begin
      imem[instr_addr] <= instr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (en) begin
      instr_q <= imem[pc];
    end
  end

  // nothing issues until a program has been written.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      loaded    <= 1'b0;
      instr_vld <= 1'b0;
    end else begin
      if (instr_we) begin
        loaded <= 1'b1;
      end
      if (en) begin
        instr_vld <= loaded;
      end
    end
  end

  ////////////////////
  // decode register
  always_ff @(posedge clk) begin
    if (!rst_n || (en && !instr_vld)) begin
      ctrl.op       <= op_pass_a;  // idle slot, no fifo or rf traffic.
      ctrl.src_a    <= src_in_a;
      ctrl.src_b    <= src_in_b;
      ctrl.dst      <= dst_out_a;
      ctrl.rf_raddr <= '0;
      ctrl.rf_waddr <= '0;
    end else if (en) begin
      ctrl.op       <= alu_op_e'(instr_q[I_OP_MSB:I_OP_LSB]);
      ctrl.src_a    <= src_e'(instr_q[I_SRCA_MSB:I_SRCA_LSB]);
      ctrl.src_b    <= src_e'(instr_q[I_SRCB_MSB:I_SRCB_LSB]);
      ctrl.dst      <= dst_e'(instr_q[I_DST_MSB:I_DST_LSB]);
      ctrl.rf_raddr <= instr_q[I_RADDR_MSB:I_RADDR_LSB];
      ctrl.rf_waddr <= instr_q[I_WADDR_MSB:I_WADDR_LSB];
    end
  end

  a_pc_bound : assert property (@(posedge clk) disable iff (!rst_n)
    en |-> (pc <= pc_max));

endmodule

`default_nettype wire

// ==== logic/pe_execute.sv ====
`default_nettype none

module pe_execute (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          en,
  pe_ctrl_if.execute                    ctrl,
  input  logic [cgra_pkg::DATA_W-1:0]   ina,
  input  logic [cgra_pkg::DATA_W-1:0]   inb,
  input  logic [cgra_pkg::DATA_W-1:0]   fifo_in_data,
  output logic                          fifo_in_re,
  input  logic                          const_we,
  input  logic [cgra_pkg::RF_AW-1:0]    const_addr,
  input  logic [cgra_pkg::DATA_W-1:0]   const_data,
  input  logic                          rf_we,
  input  logic [cgra_pkg::RF_AW-1:0]    rf_waddr,
  input  logic [cgra_pkg::DATA_W-1:0]   rf_wdata,
  output logic [cgra_pkg::DATA_W-1:0]   res,
  output cgra_pkg::dst_e                res_dst,
  output logic [cgra_pkg::RF_AW-1:0]    res_waddr
);
  import cgra_pkg::*;

  logic [DATA_W-1:0] rf [2**RF_AW];
  logic [DATA_W-1:0] ina_q;
  logic [DATA_W-1:0] inb_q;
  logic [DATA_W-1:0] fifo_q;
  logic [DATA_W-1:0] rf_q;
  alu_op_e           op_q;
  src_e              src_a_q;
  src_e              src_b_q;
  dst_e              dst_q;
  logic [RF_AW-1:0]  waddr_q;
  logic [DATA_W-1:0] opa;
  logic [DATA_W-1:0] opb;
  logic [DATA_W-1:0] alu_out;

  function automatic logic [DATA_W-1:0] pick(input src_e src);
    case (src)
      src_in_a: pick = ina_q;
      src_in_b: pick = inb_q;
      src_rf:   pick = rf_q;
      default:  pick = fifo_q;
    endcase
  endfunction

  assign fifo_in_re = en && ((ctrl.src_a == src_fifo) || (ctrl.src_b == src_fifo));

  ////////////////////
  // operand sampling
  always_ff @(posedge clk) begin
    if (en) begin
      ina_q <= ina;
      inb_q <= inb;
      rf_q  <= rf[ctrl.rf_raddr];
    end
    if (fifo_in_re) begin
      fifo_q <= fifo_in_data;
    end
  end

  always_ff @(posedge clk) begin
    if (const_we) begin
      rf[const_addr] <= const_data;  // config wins over write-back.
    end else if (rf_we) begin
      rf[rf_waddr] <= rf_wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      op_q    <= op_pass_a;
      src_a_q <= src_in_a;
      src_b_q <= src_in_b;
      dst_q   <= dst_out_a;
      waddr_q <= '0;
    end else if (en) begin
      op_q    <= ctrl.op;
      src_a_q <= ctrl.src_a;
      src_b_q <= ctrl.src_b;
      dst_q   <= ctrl.dst;
      waddr_q <= ctrl.rf_waddr;
    end
  end

  ////////////////////
  // alu
  always_comb begin
    opa = pick(src_a_q);
    opb = pick(src_b_q);
    case (op_q)
      op_add:    alu_out = opa + opb;
      op_sub:    alu_out = opa - opb;
      op_mul:    alu_out = opa * opb;
      op_and:    alu_out = opa & opb;
      op_or:     alu_out = opa | opb;
      op_xor:    alu_out = opa ^ opb;
      op_shl:    alu_out = opa << opb[3:0];
      op_shr:    alu_out = opa >> opb[3:0];
      op_min:    alu_out = (opa < opb) ? opa : opb;
      op_max:    alu_out = (opa > opb) ? opa : opb;
      op_pass_a: alu_out = opa;
      default:   alu_out = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      res_dst   <= dst_out_a;
      res_waddr <= '0;
    end else if (en) begin
      res_dst   <= dst_q;
      res_waddr <= waddr_q;
    end
  end

  always_ff @(posedge clk) begin
    if (en) begin
      res <= alu_out;
    end
  end

  a_no_rf_clash : assert property (@(posedge clk) disable iff (!rst_n)
    (const_we && rf_we) |-> (const_addr != rf_waddr));

endmodule

`default_nettype wire

// ==== logic/pe_result.sv ====
`default_nettype none

module pe_result (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          en,
  input  logic [cgra_pkg::DATA_W-1:0]   res,
  input  cgra_pkg::dst_e                res_dst,
  input  logic [cgra_pkg::RF_AW-1:0]    res_waddr,
  input  logic [cgra_pkg::CNT_W-1:0]    ignore_count,
  output logic [cgra_pkg::DATA_W-1:0]   outa,
  output logic [cgra_pkg::DATA_W-1:0]   outb,
  output logic [cgra_pkg::DATA_W-1:0]   fifo_out_data,
  output logic                          fifo_out_we,
  output logic                          rf_we,
  output logic [cgra_pkg::RF_AW-1:0]    rf_waddr,
  output logic [cgra_pkg::DATA_W-1:0]   rf_wdata
);
  import cgra_pkg::*;

  logic [CNT_W-1:0] ign_cnt;
  logic             ign_done;
  logic             fifo_we_q;

  assign ign_done = ign_cnt >= ignore_count;

  // write-back goes straight to the register file.
  assign rf_we    = en && (res_dst == dst_rf);
  assign rf_waddr = res_waddr;
  assign rf_wdata = res;

  // held strobe is consumed on the next enabled edge.
  assign fifo_out_we = fifo_we_q && en;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ign_cnt   <= '0;
      fifo_we_q <= 1'b0;
    end else if (en) begin
      fifo_we_q <= (res_dst == dst_fifo) && ign_done;
      if ((res_dst == dst_fifo) && !ign_done) begin
        ign_cnt <= ign_cnt + 1'b1;  // stops at ignore_count.
      end
    end
  end

  always_ff @(posedge clk) begin
    if (en) begin
      case (res_dst)
        dst_out_a: outa          <= res;
        dst_out_b: outb          <= res;
        dst_fifo:  fifo_out_data <= res;
        default:   ;
      endcase
    end
  end

  a_we_done : assert property (@(posedge clk) disable iff (!rst_n)
    fifo_out_we |-> ign_done && !$isunknown(fifo_out_data));

endmodule

`default_nettype wire

// ==== logic/cgra_pe.sv ====
`default_nettype none

module cgra_pe #(
  parameter int PE_ID = 0
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          en,
  input  logic [cgra_pkg::CONF_W-1:0]   conf_bus_in,
  input  logic [cgra_pkg::DATA_W-1:0]   ina,
  input  logic [cgra_pkg::DATA_W-1:0]   inb,
  input  logic [cgra_pkg::DATA_W-1:0]   fifo_in_data,
  output logic [cgra_pkg::DATA_W-1:0]   outa,
  output logic [cgra_pkg::DATA_W-1:0]   outb,
  output logic [cgra_pkg::DATA_W-1:0]   fifo_out_data,
  output logic                          fifo_in_re,
  output logic                          fifo_out_we
);
  import cgra_pkg::*;

  logic               instr_we;
  logic [PC_W-1:0]    instr_addr;
  logic [INSTR_W-1:0] instr_data;
  logic               const_we;
  logic [RF_AW-1:0]   const_addr;
  logic [DATA_W-1:0]  const_data;
  logic [PC_W-1:0]    pc_max;
  logic [PC_W-1:0]    pc_loop;
  logic [CNT_W-1:0]   ignore_count;
  logic [DATA_W-1:0]  res;
  dst_e               res_dst;
  logic [RF_AW-1:0]   res_waddr;
  logic               rf_we;
  logic [RF_AW-1:0]   rf_waddr;
  logic [DATA_W-1:0]  rf_wdata;

  pe_ctrl_if ctrl ();

  pe_conf_loader #(
    .PE_ID (PE_ID)
  ) u_loader (
    .clk          (clk),
    .rst_n        (rst_n),
    .conf_bus_in  (conf_bus_in),
    .instr_we     (instr_we),
    .instr_addr   (instr_addr),
    .instr_data   (instr_data),
    .const_we     (const_we),
    .const_addr   (const_addr),
    .const_data   (const_data),
    .pc_max       (pc_max),
    .pc_loop      (pc_loop),
    .ignore_count (ignore_count)
  );

  pe_decode u_decode (
    .clk        (clk),
    .rst_n      (rst_n),
    .en         (en),
    .instr_we   (instr_we),
    .instr_addr (instr_addr),
    .instr_data (instr_data),
    .pc_max     (pc_max),
    .pc_loop    (pc_loop),
    .ctrl       (ctrl.decode)
  );

  pe_execute u_execute (
    .clk          (clk),
    .rst_n        (rst_n),
    .en           (en),
    .ctrl         (ctrl.execute),
    .ina          (ina),
    .inb          (inb),
    .fifo_in_data (fifo_in_data),
    .fifo_in_re   (fifo_in_re),
    .const_we     (const_we),
    .const_addr   (const_addr),
    .const_data   (const_data),
    .rf_we        (rf_we),
    .rf_waddr     (rf_waddr),
    .rf_wdata     (rf_wdata),
    .res          (res),
    .res_dst      (res_dst),
    .res_waddr    (res_waddr)
  );

  pe_result u_result (
    .clk           (clk),
    .rst_n         (rst_n),
    .en            (en),
    .res           (res),
    .res_dst       (res_dst),
    .res_waddr     (res_waddr),
    .ignore_count  (ignore_count),
    .outa          (outa),
    .outb          (outb),
    .fifo_out_data (fifo_out_data),
    .fifo_out_we   (fifo_out_we),
    .rf_we         (rf_we),
    .rf_waddr      (rf_waddr),
    .rf_wdata      (rf_wdata)
  );

endmodule

`default_nettype wire

// ==== bench/tb_ref_model.svh ====
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// expected alu result from the opcode table.
function automatic logic [DATA_W-1:0] alu_ref(input logic [3:0] op,
                                              input logic [DATA_W-1:0] a,
                                              input logic [DATA_W-1:0] b);
  logic [2*DATA_W-1:0] prod;
  prod = a * b;
  case (op)
    op_add:    return a + b;
    op_sub:    return a - b;
    op_mul:    return prod[DATA_W-1:0];  // low half only.
    op_and:    return a & b;
    op_or:     return a | b;
    op_xor:    return a ^ b;
    op_shl:    return a << b[3:0];
    op_shr:    return a >> b[3:0];
    op_min:    return (a < b) ? a : b;
    op_max:    return (a > b) ? a : b;
    op_pass_a: return a;
    default:   return '0;
  endcase
endfunction

`endif

// ==== bench/tb_cgra_pe.sv ====
`default_nettype none

module tb_cgra_pe;
  import cgra_pkg::*;

  `include "tb_ref_model.svh"

  localparam int PE         = 5;
  localparam int MAX_CYCLES = 2000;  // all tests together take a few hundred cycles.

  logic              clk;
  logic              rst_n;
  logic              en;
  logic [CONF_W-1:0] conf_bus_in;
  logic [DATA_W-1:0] ina;
  logic [DATA_W-1:0] inb;
  logic [DATA_W-1:0] fifo_in_data;
  logic [DATA_W-1:0] outa;
  logic [DATA_W-1:0] outb;
  logic [DATA_W-1:0] fifo_out_data;
  logic              fifo_in_re;
  logic              fifo_out_we;

  integer            seed = 38120;
  int                errors;
  int                checks;
  int                cycles;
  int                rcv_count;
  string             cur_test;
  logic [DATA_W-1:0] fifo_words [$];
  logic              fifo_pop = 1'b0;
  logic [DATA_W-1:0] exp_q [$];
  logic [3:0]        prog_op [16];
  logic [RF_AW-1:0]  prog_raddr [16];
  logic [DATA_W-1:0] rf_model [8];
  int                cur_pc_max;
  int                cur_pc_loop;
  int                slot;
  int                skip_left;
  logic [DATA_W-1:0] a_hist [64];
  logic [DATA_W-1:0] b_hist [64];

  cgra_pe #(
    .PE_ID (PE)
  ) DUT (
    .clk           (clk),
    .rst_n         (rst_n),
    .en            (en),
    .conf_bus_in   (conf_bus_in),
    .ina           (ina),
    .inb           (inb),
    .fifo_in_data  (fifo_in_data),
    .outa          (outa),
    .outb          (outb),
    .fifo_out_data (fifo_out_data),
    .fifo_in_re    (fifo_in_re),
    .fifo_out_we   (fifo_out_we)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout after %0d cycles while waiting for results", cycles);
      $display("Testbench failed");
      $finish;
    end
  end

  ////////////////////
  // input fifo model
  always @(posedge clk) begin
    fifo_pop <= rst_n && fifo_in_re;
  end

  always @(negedge clk) begin
    if (fifo_pop) begin
      void'(fifo_words.pop_front());
      fifo_in_data = fifo_words[0];  // next word after a read.
    end
  end

  task automatic check_value(input string name, input logic [DATA_W-1:0] expected,
                             input logic [DATA_W-1:0] actual);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("ERROR %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  ////////////////////
  // expected stream and comparison
  always @(posedge clk) begin
    if (rst_n && fifo_in_re) begin
      if (skip_left > 0) begin
        skip_left = skip_left - 1;  // this result never reaches the output.
      end else begin
        exp_q.push_back(alu_ref(prog_op[slot], fifo_in_data, rf_model[prog_raddr[slot]]));
      end
      slot = (slot == cur_pc_max) ? cur_pc_loop : slot + 1;
    end
    if (rst_n && fifo_out_we) begin
      assert (exp_q.size() > 0) else begin
        errors++;
        $display("%s: output FIFO written with no result outstanding", cur_test);
      end
      if (exp_q.size() > 0) begin
        check_value(cur_test, exp_q.pop_front(), fifo_out_data);
        rcv_count++;
      end
    end
  end

  function automatic logic [INSTR_W-1:0] make_instr(input logic [3:0] op,
                                                     input logic [1:0] sa,
                                                     input logic [1:0] sb,
                                                     input logic [1:0] dst,
                                                     input logic [RF_AW-1:0] ra,
                                                     input logic [RF_AW-1:0] wa);
    logic [INSTR_W-1:0] w;
    w = '0;
    w[I_OP_MSB:I_OP_LSB]       = op;
    w[I_SRCA_MSB:I_SRCA_LSB]   = sa;
    w[I_SRCB_MSB:I_SRCB_LSB]   = sb;
    w[I_DST_MSB:I_DST_LSB]     = dst;
    w[I_RADDR_MSB:I_RADDR_LSB] = ra;
    w[I_WADDR_MSB:I_WADDR_LSB] = wa;
    return w;
  endfunction

  function automatic logic [CONF_W-1:0] make_conf(input int id, input logic [3:0] cmd,
                                                  input logic [7:0] addr,
                                                  input logic [7:0] loop,
                                                  input logic [DATA_W-1:0] data);
    logic [CONF_W-1:0] w;
    w = '0;
    w[C_ID_MSB:C_ID_LSB]     = ID_W'(id);
    w[C_CMD_MSB:C_CMD_LSB]   = cmd;
    w[C_ADDR_MSB:C_ADDR_LSB] = addr;
    w[C_LOOP_MSB:C_LOOP_LSB] = loop;
    w[C_DATA_MSB:C_DATA_LSB] = data;
    return w;
  endfunction

  task automatic send_conf(input logic [CONF_W-1:0] word);
    @(negedge clk);
    conf_bus_in = word;
  endtask

  task automatic load_instr(input int id, input logic [7:0] addr,
                            input logic [INSTR_W-1:0] instr);
    send_conf(make_conf(id, cmd_instr, addr, 8'd0, instr));
  endtask

  task automatic load_const(input int id, input logic [RF_AW-1:0] addr,
                            input logic [DATA_W-1:0] value);
    send_conf(make_conf(id, cmd_const, 8'(addr), 8'd0, value));
    if (id == PE) begin
      rf_model[addr] = value;
    end
  endtask

  task automatic set_pc(input int id, input int max, input int loop);
    send_conf(make_conf(id, cmd_pc, 8'(max), 8'(loop), '0));
    if (id == PE) begin
      cur_pc_max  = max;
      cur_pc_loop = loop;
    end
  endtask

  task automatic set_ignore(input int id, input int n);
    send_conf(make_conf(id, cmd_ignore, 8'd0, 8'(n), '0));
    if (id == PE) begin
      skip_left = n;
    end
  endtask

  task automatic settle();
    @(negedge clk);
    conf_bus_in = '0;  // command 0 is an idle bus.
    repeat (2) @(negedge clk);
  endtask

  task automatic apply_reset();
    @(negedge clk);
    rst_n       = 1'b0;
    en          = 1'b0;
    conf_bus_in = '0;
    exp_q.delete();
    slot      = 0;
    skip_left = 0;
    rcv_count = 0;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
  endtask

  task automatic check_quiet(input int n);
    repeat (n) begin
      @(negedge clk);
      checks++;
      assert ((fifo_in_re === 1'b0) && (fifo_out_we === 1'b0)) else begin
        errors++;
        $display("%s: a FIFO strobe went high while the PE had to stay idle", cur_test);
      end
    end
  endtask

  task automatic run_until(input int n);
    @(negedge clk);
    en = 1'b1;
    while (rcv_count < n) begin
      @(negedge clk);
    end
    en = 1'b0;
  endtask

  initial begin
    int k;
    int j;
    logic [3:0] op;
    rst_n       = 1'b0;
    en          = 1'b0;
    conf_bus_in = '0;
    ina         = '0;
    inb         = '0;
    for (int i = 0; i < 2048; i++) begin
      fifo_words.push_back(DATA_W'($random(seed)));
    end
    fifo_in_data = fifo_words[0];

    // quiet after reset, then every opcode against a constant.
    cur_test = "reset_quiet";
    apply_reset();
    for (k = 0; k < 8; k++) begin
      load_const(PE, RF_AW'(k), DATA_W'($random(seed)));
    end
    for (k = 0; k < 12; k++) begin
      op = (k < 11) ? 4'(k) : 4'hf;  // code 15 is unused.
      prog_op[k]    = op;
      prog_raddr[k] = RF_AW'(k % 8);
      load_instr(PE, 8'(k), make_instr(op, src_fifo, src_rf, dst_fifo, RF_AW'(k % 8), '0));
    end
    set_pc(PE, 11, 0);
    settle();
    check_quiet(6);
    cur_test = "all_opcodes";
    run_until(24);

    cur_test = "foreign_id";
    apply_reset();
    load_const(3, '0, 16'h1234);
    load_instr(3, 8'd0, make_instr(op_add, src_fifo, src_rf, dst_fifo, '0, '0));
    set_pc(3, 0, 0);
    settle();
    @(negedge clk);
    en = 1'b1;
    check_quiet(30);
    en = 1'b0;

    cur_test = "add_sub_out";
    apply_reset();
    load_instr(PE, 8'd0, make_instr(op_add, src_in_a, src_in_b, dst_out_a, '0, '0));
    load_instr(PE, 8'd1, make_instr(op_sub, src_in_a, src_in_b, dst_out_b, '0, '0));
    set_pc(PE, 1, 0);
    settle();
    for (k = 0; k < 24; k++) begin
      @(negedge clk);
      if (k >= 5) begin
        j = k - 3;  // operands driven at j belong to slot (j - 2) mod 2.
        if ((j % 2) == 0) begin
          check_value("add_to_outa", a_hist[j] + b_hist[j], outa);
        end else begin
          check_value("sub_to_outb", a_hist[j] - b_hist[j], outb);
        end
      end
      a_hist[k] = DATA_W'($random(seed));
      b_hist[k] = DATA_W'($random(seed));
      ina       = a_hist[k];
      inb       = b_hist[k];
      en        = 1'b1;
    end
    @(negedge clk);
    en = 1'b0;

    cur_test = "ignore_count";
    apply_reset();
    load_const(PE, 3'd2, DATA_W'($random(seed)));
    prog_op[0]    = op_add;
    prog_raddr[0] = 3'd2;
    load_instr(PE, 8'd0, make_instr(op_add, src_fifo, src_rf, dst_fifo, 3'd2, '0));
    set_pc(PE, 0, 0);
    set_ignore(PE, 4);
    settle();
    run_until(10);

    cur_test = "pc_loop";
    apply_reset();
    prog_op[0] = op_add;
    prog_op[1] = op_xor;
    prog_op[2] = op_sub;
    prog_op[3] = op_max;
    for (k = 0; k < 4; k++) begin
      load_const(PE, RF_AW'(k), DATA_W'($random(seed)));
      prog_raddr[k] = RF_AW'(k);
      load_instr(PE, 8'(k), make_instr(prog_op[k], src_fifo, src_rf, dst_fifo, RF_AW'(k), '0));
    end
    set_pc(PE, 3, 1);
    settle();
    run_until(14);

    @(negedge clk);
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+bench
logic/cgra_pkg.sv
logic/pe_ctrl_if.sv
logic/pe_conf_loader.sv
logic/pe_decode.sv
logic/pe_execute.sv
logic/pe_result.sv
logic/cgra_pe.sv
bench/tb_cgra_pe.sv

// ==== Bender.yml ====
package:
  name: cgra_pe

sources:
  - files:
      - logic/cgra_pkg.sv
      - logic/pe_ctrl_if.sv
      - logic/pe_conf_loader.sv
      - logic/pe_decode.sv
      - logic/pe_execute.sv
      - logic/pe_result.sv
      - logic/cgra_pe.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/tb_cgra_pe.sv
